//--- source/ldpc_pkg.sv
package ldpc_pkg;

	// check node degree and message widths
	localparam int CN_DEGREE = 6;
	localparam int MAG_BITS  = 3;
	localparam int IDX_BITS  = 3;

	// offset min-sum correction subtracted from each minimum
	localparam logic [MAG_BITS-1:0] OFFSET = MAG_BITS'(1);

	// check node arithmetic mode
	typedef enum logic {
		MODE_MS  = 1'b0,
		MODE_OMS = 1'b1
	} cnu_mode_e;

	// one message, sign and magnitude
	typedef struct packed {
		logic                sign;
		logic [MAG_BITS-1:0] mag;
	} msg_t;

	// all messages of one check node
	// entry k sits at bits [4k+3:4k]
	typedef struct packed {
		msg_t [CN_DEGREE-1:0] msg;
	} msg_bundle_t;

	// minimum, second minimum and where they came from
	typedef struct packed {
		logic [MAG_BITS-1:0] min1;
		logic [MAG_BITS-1:0] min2;
		logic [IDX_BITS-1:0] min1_idx;
		logic [IDX_BITS-1:0] min2_idx;
	} min_info_t;

endpackage

//--- source/min_sort_4.sv
`timescale 1ns/1ns

module min_sort_4 (
	input  logic [ldpc_pkg::MAG_BITS-1:0] lo_a,
	input  logic [ldpc_pkg::MAG_BITS-1:0] hi_a,
	input  logic [ldpc_pkg::MAG_BITS-1:0] lo_b,
	input  logic [ldpc_pkg::MAG_BITS-1:0] hi_b,
	output logic [1:0]                    min_pos,
	output logic [1:0]                    second_pos
);

	import ldpc_pkg::*;

	// port order positions
	localparam logic [1:0] POS_LO_A = 2'd0;
	localparam logic [1:0] POS_HI_A = 2'd1;
	localparam logic [1:0] POS_LO_B = 2'd2;
	localparam logic [1:0] POS_HI_B = 2'd3;

	logic a_wins;
	logic a_partner_first;
	logic b_partner_later;

	// pair minima decide the overall minimum
	// equal values go to pair a, the lower positions
	assign a_wins = (lo_a <= lo_b);

	// a won, so its partner races the minimum of b
	assign a_partner_first = (hi_a <= lo_b);

	// b won, so the minimum of a races the partner of b
	assign b_partner_later = (hi_b < lo_a);

	always_comb begin
		if (a_wins) begin
			min_pos = POS_LO_A;
			if (a_partner_first) begin
				second_pos = POS_HI_A;
			end else begin
				second_pos = POS_LO_B;
			end
		end else begin
			min_pos = POS_LO_B;
			if (b_partner_later) begin
				second_pos = POS_HI_B;
			end else begin
				second_pos = POS_LO_A;
			end
		end
	end

endmodule

//--- source/cnu_min_6.sv
`timescale 1ns/1ns

module cnu_min_6 (
	input  logic [ldpc_pkg::MAG_BITS-1:0] mags [ldpc_pkg::CN_DEGREE],
	output ldpc_pkg::min_info_t           min_info
);

	import ldpc_pkg::*;

	// ordered message positions of each pair, [0] is the smaller one
	logic [IDX_BITS-1:0] pair_idx [CN_DEGREE/2][2];

	// positions after the first sorter
	logic [IDX_BITS-1:0] mid_idx [2];

	// local results of both sorters
	logic [1:0] d2_min_pos;
	logic [1:0] d2_second_pos;
	logic [1:0] d3_min_pos;
	logic [1:0] d3_second_pos;

	logic [IDX_BITS-1:0] min1_idx;
	logic [IDX_BITS-1:0] min2_idx;

	// local sorter position back to message position
	function automatic logic [IDX_BITS-1:0] map_pos(
		input logic [1:0]          pos,
		input logic [IDX_BITS-1:0] lo_a,
		input logic [IDX_BITS-1:0] hi_a,
		input logic [IDX_BITS-1:0] lo_b,
		input logic [IDX_BITS-1:0] hi_b
	);
		logic [IDX_BITS-1:0] idx;
		case (pos)
			2'd0:    idx = lo_a;
			2'd1:    idx = hi_a;
			2'd2:    idx = lo_b;
			default: idx = hi_b;
		endcase
		return idx;
	endfunction

	// depth one, compare neighbours of each pair
	for (genvar p = 0; p < CN_DEGREE/2; p++) begin : g_pair
		logic even_first;

		// ties keep the even, lower position first
		assign even_first = (mags[2*p] <= mags[2*p+1]);
		assign pair_idx[p][0] = even_first ? IDX_BITS'(2*p) : IDX_BITS'(2*p+1);
		assign pair_idx[p][1] = even_first ? IDX_BITS'(2*p+1) : IDX_BITS'(2*p);
	end

	// depth two, pairs 0 and 1
	min_sort_4 u_sort_d2 (
		.lo_a       (mags[pair_idx[0][0]]),
		.hi_a       (mags[pair_idx[0][1]]),
		.lo_b       (mags[pair_idx[1][0]]),
		.hi_b       (mags[pair_idx[1][1]]),
		.min_pos    (d2_min_pos),
		.second_pos (d2_second_pos)
	);

	assign mid_idx[0] = map_pos(d2_min_pos, pair_idx[0][0], pair_idx[0][1],
		pair_idx[1][0], pair_idx[1][1]);
	assign mid_idx[1] = map_pos(d2_second_pos, pair_idx[0][0], pair_idx[0][1],
		pair_idx[1][0], pair_idx[1][1]);

	// depth three, first four against pair 2
	min_sort_4 u_sort_d3 (
		.lo_a       (mags[mid_idx[0]]),
		.hi_a       (mags[mid_idx[1]]),
		.lo_b       (mags[pair_idx[2][0]]),
		.hi_b       (mags[pair_idx[2][1]]),
		.min_pos    (d3_min_pos),
		.second_pos (d3_second_pos)
	);

	assign min1_idx = map_pos(d3_min_pos, mid_idx[0], mid_idx[1],
		pair_idx[2][0], pair_idx[2][1]);
	assign min2_idx = map_pos(d3_second_pos, mid_idx[0], mid_idx[1],
		pair_idx[2][0], pair_idx[2][1]);

	// read the magnitudes back at the winning positions
	assign min_info.min1     = mags[min1_idx];
	assign min_info.min2     = mags[min2_idx];
	assign min_info.min1_idx = min1_idx;
	assign min_info.min2_idx = min2_idx;

endmodule

//--- source/c2v_gen.sv
`timescale 1ns/1ns

module c2v_gen (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  in_valid,
	input  ldpc_pkg::msg_bundle_t in_msgs,
	input  ldpc_pkg::cnu_mode_e   mode,
	input  ldpc_pkg::min_info_t   min_info,
	output logic                  out_valid,
	output ldpc_pkg::msg_bundle_t out_msgs,
	output ldpc_pkg::min_info_t   out_min
);

	import ldpc_pkg::*;

	logic [CN_DEGREE-1:0] in_signs;

	// stage 1 registers
	logic                 s1_valid;
	min_info_t            s1_min;
	logic [CN_DEGREE-1:0] s1_signs;
	logic                 s1_parity;
	cnu_mode_e            s1_mode;

	// stage 2 combinational results
	logic [MAG_BITS-1:0]  adj_min1;
	logic [MAG_BITS-1:0]  adj_min2;
	msg_bundle_t          next_msgs;

	// subtract the offset, saturating at zero
	function automatic logic [MAG_BITS-1:0] sub_offset(input logic [MAG_BITS-1:0] mag);
		logic [MAG_BITS-1:0] res;
		if (mag > OFFSET) begin
			res = mag - OFFSET;
		end else begin
			res = '0;
		end
		return res;
	endfunction

	always_comb begin
		for (int k = 0; k < CN_DEGREE; k++) begin
			in_signs[k] = in_msgs.msg[k].sign;
		end
	end

	// stage 1, capture minima, signs and mode
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			s1_valid  <= 1'b0;
			s1_min    <= '0;
			s1_signs  <= '0;
			s1_parity <= 1'b0;
			s1_mode   <= MODE_MS;
		end else begin
			s1_valid <= in_valid;
			if (in_valid) begin
				s1_min    <= min_info;
				s1_signs  <= in_signs;
				s1_parity <= ^in_signs;
				s1_mode   <= mode;
			end
		end
	end

	// offset only in offset min-sum mode
	assign adj_min1 = (s1_mode == MODE_OMS) ? sub_offset(s1_min.min1) : s1_min.min1;
	assign adj_min2 = (s1_mode == MODE_OMS) ? sub_offset(s1_min.min2) : s1_min.min2;

	// the minimum's own position gets the second minimum
	always_comb begin
		for (int k = 0; k < CN_DEGREE; k++) begin
			next_msgs.msg[k].sign = s1_parity ^ s1_signs[k];
			if (s1_min.min1_idx == IDX_BITS'(k)) begin
				next_msgs.msg[k].mag = adj_min2;
			end else begin
				next_msgs.msg[k].mag = adj_min1;
			end
		end
	end

	// stage 2, register the outgoing messages
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
			out_msgs  <= '0;
			out_min   <= '0;
		end else begin
			out_valid <= s1_valid;
			if (s1_valid) begin
				out_msgs <= next_msgs;
				out_min  <= s1_min;
			end
		end
	end

endmodule

//--- source/cnu_top.sv
`timescale 1ns/1ns

module cnu_top (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  in_valid,
	input  ldpc_pkg::msg_bundle_t in_msgs,
	input  ldpc_pkg::cnu_mode_e   mode,
	output logic                  out_valid,
	output ldpc_pkg::msg_bundle_t out_msgs,
	output ldpc_pkg::min_info_t   out_min
);

	import ldpc_pkg::*;

	logic [MAG_BITS-1:0] mags [CN_DEGREE];
	min_info_t           min_info;

	// magnitudes only, signs go straight to the generator
	always_comb begin
		for (int k = 0; k < CN_DEGREE; k++) begin
			mags[k] = in_msgs.msg[k].mag;
		end
	end

	// min finder, no latency
	cnu_min_6 u_cnu_min_6 (
		.mags     (mags),
		.min_info (min_info)
	);

	// two register stages to the outputs
	c2v_gen u_c2v_gen (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.in_msgs   (in_msgs),
		.mode      (mode),
		.min_info  (min_info),
		.out_valid (out_valid),
		.out_msgs  (out_msgs),
		.out_min   (out_min)
	);

endmodule

//--- testbench/tb_cnu_top.sv
`timescale 1ns/1ns

module tb_cnu_top;

	import ldpc_pkg::*;

	localparam int RESET_CYCLES = 10;
	localparam int DIR_COUNT    = 13;
	localparam int RAND_COUNT   = 300;
	localparam int DRAIN_LIMIT  = 20;
	localparam int MSG_BITS     = CN_DEGREE * (MAG_BITS + 1);

	// one directed vector with its expected minima
	typedef struct packed {
		cnu_mode_e           mode;
		msg_bundle_t         msgs;
		logic [MAG_BITS-1:0] min1;
		logic [MAG_BITS-1:0] min2;
	} dir_vec_t;

	// expected result of one strobe
	typedef struct packed {
		msg_bundle_t         msgs;
		logic [MAG_BITS-1:0] min1;
		logic [MAG_BITS-1:0] min2;
		logic [IDX_BITS-1:0] min1_idx;
		logic [IDX_BITS-1:0] min2_idx;
		logic                idx_unique;
		logic                idx2_unique;
		int                  due;
	} exp_t;

	// nibble k of msgs is message k with the sign in its top bit
	localparam dir_vec_t DIR_TABLE [DIR_COUNT] = '{
		'{MODE_MS,  24'h333333, 3'd3, 3'd3},
		'{MODE_MS,  24'h654731, 3'd1, 3'd3},
		'{MODE_OMS, 24'hC5E70A, 3'd0, 3'd2},
		'{MODE_MS,  24'hC7396D, 3'd1, 3'd3},
		'{MODE_OMS, 24'hF3A5C6, 3'd2, 3'd3},
		'{MODE_OMS, 24'h98F7F7, 3'd0, 3'd1},
		'{MODE_MS,  24'h273456, 3'd2, 3'd3},
		'{MODE_MS,  24'h51D595, 3'd1, 3'd1},
		'{MODE_OMS, 24'h51D595, 3'd1, 3'd1},
		'{MODE_MS,  24'h777777, 3'd7, 3'd7},
		'{MODE_OMS, 24'hFFFFFF, 3'd7, 3'd7},
		'{MODE_OMS, 24'h000000, 3'd0, 3'd0},
		'{MODE_MS,  24'h888880, 3'd0, 3'd0}
	};

	logic        clk = 1'b0;
	logic        arst_n;
	logic        in_valid;
	msg_bundle_t in_msgs;
	cnu_mode_e   mode;
	logic        out_valid;
	msg_bundle_t out_msgs;
	min_info_t   out_min;

	int          cycle_count = 0;
	logic [15:0] lfsr_state = 16'd39688;
	exp_t        exp_q [$];

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	cnu_top u_cnu_top (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.in_msgs   (in_msgs),
		.mode      (mode),
		.out_valid (out_valid),
		.out_msgs  (out_msgs),
		.out_min   (out_min)
	);

	task automatic abort_sim();
		$display("sim failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic report_mismatch(input string msg);
		$display("[FAIL] %0t ns %s", $time, msg);
		abort_sim();
	endtask

	task automatic report_problem(input string msg);
		$display("error at %0t ns, %s", $time, msg);
		abort_sim();
	endtask

	// galois lfsr with taps for a maximal 16-bit sequence
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic [15:0] nxt;
		nxt = s >> 1;
		if (s[0]) begin
			nxt = nxt ^ 16'hB400;
		end
		return nxt;
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int b = 0; b < n; b++) begin
			val = {val[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return val;
	endfunction

	// expected outputs straight from the min-sum rules
	function automatic exp_t model_result(input msg_bundle_t m, input cnu_mode_e md);
		exp_t                e;
		logic [IDX_BITS-1:0] i1;
		logic [IDX_BITS-1:0] i2;
		logic [MAG_BITS-1:0] o1;
		logic [MAG_BITS-1:0] o2;
		logic                par;
		int                  cnt;
		int                  cnt2;
		i1 = '0;
		for (int k = 1; k < CN_DEGREE; k++) begin
			if (m.msg[k].mag < m.msg[i1].mag) begin
				i1 = IDX_BITS'(k);
			end
		end
		// second minimum over the other five with lowest position on ties
		i2 = (i1 == '0) ? IDX_BITS'(1) : '0;
		for (int k = 0; k < CN_DEGREE; k++) begin
			if (IDX_BITS'(k) != i1 && m.msg[k].mag < m.msg[i2].mag) begin
				i2 = IDX_BITS'(k);
			end
		end
		cnt  = 0;
		cnt2 = 0;
		par  = 1'b0;
		for (int k = 0; k < CN_DEGREE; k++) begin
			if (m.msg[k].mag == m.msg[i1].mag) begin
				cnt++;
			end
			if (m.msg[k].mag == m.msg[i2].mag) begin
				cnt2++;
			end
			par = par ^ m.msg[k].sign;
		end
		e.min1        = m.msg[i1].mag;
		e.min2        = m.msg[i2].mag;
		e.min1_idx    = i1;
		e.min2_idx    = i2;
		e.idx_unique  = (cnt == 1);
		e.idx2_unique = (cnt == 1) && (cnt2 == 1);
		e.due         = 0;
		o1 = e.min1;
		o2 = e.min2;
		if (md == MODE_OMS) begin
			o1 = (o1 >= OFFSET) ? o1 - OFFSET : '0;
			o2 = (o2 >= OFFSET) ? o2 - OFFSET : '0;
		end
		for (int k = 0; k < CN_DEGREE; k++) begin
			e.msgs.msg[k].sign = par ^ m.msg[k].sign;
			e.msgs.msg[k].mag  = (IDX_BITS'(k) == i1) ? o2 : o1;
		end
		return e;
	endfunction

	task automatic send_vector(input msg_bundle_t msgs, input cnu_mode_e md);
		exp_t e;
		@(negedge clk);
		e = model_result(msgs, md);
		// result due two rising edges later
		e.due    = cycle_count + 2;
		in_valid = 1'b1;
		in_msgs  = msgs;
		mode     = md;
		exp_q.push_back(e);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge clk);
			in_valid = 1'b0;
		end
	endtask

	// registered outputs are settled by the falling edge
	always @(negedge clk) begin : check_outputs
		exp_t e;
		if (out_valid) begin
			assert (exp_q.size() != 0)
			else report_problem("out_valid went high with no strobe pending");
			e = exp_q.pop_front();
			assert (e.due == cycle_count)
			else report_mismatch($sformatf("out_valid at cycle %0d, expected at cycle %0d",
				cycle_count, e.due));
			assert (out_min.min1 == e.min1 && out_min.min2 == e.min2)
			else report_mismatch($sformatf("minima %0d/%0d, expected %0d/%0d",
				out_min.min1, out_min.min2, e.min1, e.min2));
			if (e.idx_unique) begin
				assert (out_min.min1_idx == e.min1_idx)
				else report_mismatch($sformatf("min1_idx %0d, expected %0d",
					out_min.min1_idx, e.min1_idx));
			end
			if (e.idx2_unique) begin
				assert (out_min.min2_idx == e.min2_idx)
				else report_mismatch($sformatf("min2_idx %0d, expected %0d",
					out_min.min2_idx, e.min2_idx));
			end
			assert (out_msgs == e.msgs)
			else report_mismatch($sformatf("out_msgs 0x%06h, expected 0x%06h",
				out_msgs, e.msgs));
		end else if (exp_q.size() != 0) begin
			assert (exp_q[0].due > cycle_count)
			else report_problem($sformatf("no result at cycle %0d for a pending strobe",
				exp_q[0].due));
		end
	end

	initial begin : stimulus
		exp_t        chk;
		logic [31:0] rnd;
		msg_bundle_t msgs;
		cnu_mode_e   md;
		int          gap;
		int          wait_cycles;
		in_valid = 1'b0;
		in_msgs  = '0;
		mode     = MODE_MS;
		arst_n   = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		arst_n = 1'b1;
		assert (out_valid == 1'b0)
		else report_mismatch("out_valid high right after reset");
		idle_cycles(2);

		// directed table with strobes back to back and mixed modes
		for (int i = 0; i < DIR_COUNT; i++) begin
			chk = model_result(DIR_TABLE[i].msgs, DIR_TABLE[i].mode);
			assert (chk.min1 == DIR_TABLE[i].min1 && chk.min2 == DIR_TABLE[i].min2)
			else report_problem($sformatf("directed vector %0d minima disagree with the model",
				i));
			send_vector(DIR_TABLE[i].msgs, DIR_TABLE[i].mode);
		end
		idle_cycles(3);

		// same table again with a gap after every strobe
		for (int i = 0; i < DIR_COUNT; i++) begin
			send_vector(DIR_TABLE[i].msgs, DIR_TABLE[i].mode);
			idle_cycles(1);
		end
		idle_cycles(2);

		// random vectors with gaps of zero to three cycles
		for (int i = 0; i < RAND_COUNT; i++) begin
			rnd  = take_bits(MSG_BITS);
			msgs = rnd[MSG_BITS-1:0];
			rnd  = take_bits(1);
			md   = cnu_mode_e'(rnd[0]);
			send_vector(msgs, md);
			rnd = take_bits(2);
			gap = int'(rnd[1:0]);
			idle_cycles(gap);
		end
		idle_cycles(1);

		wait_cycles = 0;
		while (exp_q.size() != 0 && wait_cycles < DRAIN_LIMIT) begin
			@(posedge clk);
			wait_cycles++;
		end
		assert (exp_q.size() == 0)
		else report_problem("timeout while waiting for the last results");

		// quiet tail where the checker catches any stray out_valid
		idle_cycles(4);
		$display("sim passed");
		$finish;
	end

endmodule

//--- cnu_top.f
source/ldpc_pkg.sv
source/min_sort_4.sv
source/cnu_min_6.sv
source/c2v_gen.sv
source/cnu_top.sv
testbench/tb_cnu_top.sv

//--- Makefile
SIM_LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/Vtb_cnu_top: cnu_top.f source/*.sv testbench/*.sv
	verilator --binary --timing --assert -j 0 -f cnu_top.f --top-module tb_cnu_top

run: obj_dir/Vtb_cnu_top
	./obj_dir/Vtb_cnu_top 2>&1 | tee $(SIM_LOG)
	grep -qx "sim passed" $(SIM_LOG)

lint:
	verilator --lint-only -Wall --top-module cnu_top \
		source/ldpc_pkg.sv source/min_sort_4.sv source/cnu_min_6.sv \
		source/c2v_gen.sv source/cnu_top.sv

clean:
	rm -rf obj_dir $(SIM_LOG)
